//--- flist.f
logic/ddr_pkg.sv
logic/conv_pkg.sv
logic/conv_ctrl.sv
logic/quan_reader.sv
logic/quant_fifo.sv
logic/quan_writer.sv
logic/conv_top.sv
tb/conv_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = conv_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# build and run, status comes from the search for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "sim passed"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/conv_stimulus.mem
// source words, four signed 16 bit lanes each, lane 0 in the low bits (16 lines)
// then expected write words, odd source word quantized high, even word low (8 lines)
0010_0008_0007_0000
07F8_07F7_FFF7_FFF8
F807_F808_8000_7FFF
FF00_0100_F7F7_F7F8
FEDC_0459_0123_1234
0017_FFE7_FFE8_0018
FC08_03F8_FC00_0400
FFAA_0055_AAAA_5555
FFF0_000F_FFFF_0001
F817_F818_07E7_07E8
F600_0A00_FCE0_0320
0038_0028_0018_0008
FFC8_FFD8_FFE8_FFF8
F810_07F0_F800_0800
FABC_0789_0456_0123
FF99_0066_C3C3_3C3C
7F7FFF00_01010000
F0108080_8081807F
01FEFF02_EE46127F
FB05807F_C140C040
81827E7F_FF010000
04030201_807FCE32
817F807F_FDFEFF00
FA06807F_AC794512

//--- tb/conv_tb.sv
`default_nettype none

module conv_tb
  import ddr_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int                    TEST_SIZE = 16;
  localparam int                    PAIRS     = TEST_SIZE / 2;
  localparam int                    RST_CNT   = 16;   // short init for sim
  localparam logic [ADDR_WIDTH-1:0] SRC_BASE  = 29'h0000040;
  localparam logic [ADDR_WIDTH-1:0] DST_BASE  = 29'h0000100;
  localparam int                    CLK_NS    = 40;
  localparam int                    WD_CYCLES = 2 * (RST_CNT + 100 + TEST_SIZE * 9);

  logic        clk_40M;
  logic        clk_40MHz_locked;
  logic        test_start;
  logic        test_ready;
  logic        test_done;
  ddr_rd_req_t rd_req;
  ddr_rd_rsp_t rd_rsp   = '0;
  ddr_wr_req_t wr_req;
  logic        wr_ready = 1'b0;

  logic [UI_WIDTH-1:0] stim [TEST_SIZE + PAIRS];  // sources followed by expected writes
  logic [UI_WIDTH-1:0] rsp_data_q [$];             // read returns in flight
  int                  rsp_due_q [$];              // cycle each return is due
  logic [31:0]         lfsr = 32'h3d3db686;
  ddr_wr_req_t         held_wr;
  logic                wr_stalled = 1'b0;
  logic                done_seen  = 1'b0;
  int                  cyc;
  int                  rd_cnt, wr_cnt;             // per run
  int                  last_wr_cyc, done_cyc;
  int                  run_id, seen_run;

  conv_top #(
    .TEST_SIZE(TEST_SIZE), .QUANT_SHIFT(4), .FIFO_DEPTH(8), .RST_CNT(RST_CNT),
    .SRC_BASE(SRC_BASE), .DST_BASE(DST_BASE)
  ) uut (.*);

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic stop_failed();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic fail_plain(input string why);
    $display("%s", why);
    stop_failed();
  endtask

  task automatic check_wr(input string name, input ddr_wr_req_t got, input ddr_wr_req_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got en=%h adr=%h data=%h, expected en=%h adr=%h data=%h",
               name, got.en, got.adr, got.data, exp.en, exp.adr, exp.data);
      stop_failed();
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] got,
                            input logic [ADDR_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h, expected %h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h, expected %h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_idle();
    check_flag("rd_req.en", rd_req.en, 1'b0);
    check_flag("wr_req.en", wr_req.en, 1'b0);
    check_flag("test_ready", test_ready, 1'b0);
    check_flag("test_done", test_done, 1'b0);
  endtask

  // one run with a stray start while busy
  task automatic run_once();
    @(posedge clk_40M);
    run_id++;                       // model clears its counts
    @(negedge clk_40M);
    test_start = 1'b1;
    @(negedge clk_40M);
    test_start = 1'b0;
    check_flag("test_ready", test_ready, 1'b0);
    check_flag("test_done", test_done, 1'b0);
    repeat (4) @(negedge clk_40M);
    test_start = 1'b1;              // engine busy so this one is dropped
    @(negedge clk_40M);
    test_start = 1'b0;
    while (test_done !== 1'b1) @(negedge clk_40M);
    @(posedge clk_40M);
    if (rd_cnt != TEST_SIZE || wr_cnt != PAIRS)
      fail_plain("a run ended with the wrong number of reads or writes");
    if (done_cyc - last_wr_cyc != 2)
      fail_plain("test_done did not rise two cycles after the last accepted write");
  endtask

  //////////////////////////////////////////////////
  // memory model on the falling edge
  //////////////////////////////////////////////////
  always @(negedge clk_40M) begin : mem_model
    ddr_wr_req_t exp_wr;
    cyc = cyc + 1;
    if (run_id != seen_run) begin
      seen_run = run_id;
      rd_cnt   = 0;
      wr_cnt   = 0;
    end
    rd_rsp = '0;
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin  // in order and one per cycle
      rd_rsp.valid = 1'b1;
      rd_rsp.data  = rsp_data_q.pop_front();
      void'(rsp_due_q.pop_front());
    end
    if (rd_req.en) begin
      if (rd_cnt >= TEST_SIZE) fail_plain("read request after the whole source block");
      check_addr("rd_req.adr", rd_req.adr, SRC_BASE + ADDR_WIDTH'(rd_cnt));
      rsp_data_q.push_back(stim[rd_cnt]);
      rsp_due_q.push_back(cyc + 1 + int'(draw_bits(2)));  // 1 to 4 cycles
      rd_cnt++;
    end
    if (wr_stalled) check_wr("wr_req", wr_req, held_wr);  // held while stalled
    wr_ready = (draw_bits(2) != '0);  // low about one cycle in four
    if (wr_req.en && wr_ready) begin
      if (wr_cnt >= PAIRS) fail_plain("write request after the whole result block");
      exp_wr = '{en: 1'b1, adr: DST_BASE + ADDR_WIDTH'(wr_cnt), data: stim[TEST_SIZE + wr_cnt]};
      check_wr("wr_req", wr_req, exp_wr);
      wr_cnt++;
      last_wr_cyc = cyc;
    end
    wr_stalled = wr_req.en && !wr_ready;
    held_wr    = wr_req;
    if (test_done && !done_seen) done_cyc = cyc;  // rising edge of done
    done_seen = test_done;
  end

  //////////////////////////////////////////////////
  // clock, watchdog, sequence
  //////////////////////////////////////////////////
  initial begin : clock_gen
    clk_40M = 1'b0;
    forever #(CLK_NS / 2) clk_40M = ~clk_40M;
  end

  initial begin : watchdog
    #(WD_CYCLES * CLK_NS);
    fail_plain("watchdog expired before the test sequence finished");
  end

  initial begin : main_seq
    clk_40MHz_locked = 1'b1;        // drops on the first falling edge
    test_start       = 1'b0;
    $readmemh("tb/conv_stimulus.mem", stim);
    if ($isunknown(stim[TEST_SIZE + PAIRS - 1])) fail_plain("stimulus file missing or short");
    @(negedge clk_40M);
    clk_40MHz_locked = 1'b0;
    repeat (4) begin
      @(negedge clk_40M);
      check_idle();
    end
    clk_40MHz_locked = 1'b1;
    repeat (RST_CNT - 1) begin      // still in init
      @(negedge clk_40M);
      check_idle();
    end
    @(negedge clk_40M);
    check_flag("test_ready", test_ready, 1'b1);
    run_once();
    run_once();                     // repeat from done with the same results
    // done and ready hold with the engine quiet until a new start
    repeat (8) begin
      @(negedge clk_40M);
      check_flag("test_done", test_done, 1'b1);
      check_flag("test_ready", test_ready, 1'b1);
      check_flag("rd_req.en", rd_req.en, 1'b0);
      check_flag("wr_req.en", wr_req.en, 1'b0);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/conv_top.sv
`default_nettype none

module conv_top
  import ddr_pkg::*;
  import conv_pkg::*;
#(
  parameter int                    TEST_SIZE   = 16,
  parameter int                    QUANT_SHIFT = 4,
  parameter int                    FIFO_DEPTH  = 8,
  parameter int                    RST_CNT     = 2000,
  parameter logic [ADDR_WIDTH-1:0] SRC_BASE    = 29'h0000000,
  parameter logic [ADDR_WIDTH-1:0] DST_BASE    = 29'h0000100
) (
  input  wire         clk_40M,
  input  wire         clk_40MHz_locked,  // async reset, active low
  input  wire         test_start,
  output logic        test_ready,
  output logic        test_done,
  output ddr_rd_req_t rd_req,
  input  ddr_rd_rsp_t rd_rsp,
  output ddr_wr_req_t wr_req,
  input  wire         wr_ready
);

  localparam int LVL_W = $clog2(FIFO_DEPTH + 1);

  logic             rst;
  logic             run_start;
  logic             run_end;
  logic             push;       // reader to fifo
  quant_word_t      push_data;
  logic [LVL_W-1:0] level;      // fifo fill back to reader
  logic             pop;        // writer to fifo
  logic             empty;
  quant_word_t      pop_data;

  conv_ctrl #(.RST_CNT(RST_CNT)) u_ctrl (
    .clk_40M, .clk_40MHz_locked, .test_start, .run_end,
    .rst, .run_start, .test_ready, .test_done
  );

  // producer
  quan_reader #(
    .TEST_SIZE(TEST_SIZE), .QUANT_SHIFT(QUANT_SHIFT),
    .FIFO_DEPTH(FIFO_DEPTH), .SRC_BASE(SRC_BASE)
  ) u_reader (
    .clk_40M, .clk_40MHz_locked, .rst, .run_start, .rd_rsp, .level,
    .rd_req, .push, .push_data
  );

  // buffer
  quant_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk_40M, .clk_40MHz_locked, .rst, .push, .push_data, .pop,
    .pop_data, .empty, .level
  );

  // consumer
  quan_writer #(.TEST_SIZE(TEST_SIZE), .DST_BASE(DST_BASE)) u_writer (
    .clk_40M, .clk_40MHz_locked, .rst, .run_start, .empty, .pop_data, .wr_ready,
    .pop, .wr_req, .run_end
  );

endmodule

`default_nettype wire

//--- logic/quan_writer.sv
`default_nettype none

module quan_writer
  import ddr_pkg::*;
  import conv_pkg::*;
#(
  parameter int                    TEST_SIZE = 16,
  parameter logic [ADDR_WIDTH-1:0] DST_BASE  = '0
) (
  input  wire         clk_40M,
  input  wire         clk_40MHz_locked,
  input  wire         rst,
  input  wire         run_start,
  input  wire         empty,
  input  quant_word_t pop_data,
  input  wire         wr_ready,
  output logic        pop,
  output ddr_wr_req_t wr_req,
  output logic        run_end    // pulse after last accepted write
);

  localparam int PAIRS = TEST_SIZE / 2;
  localparam int WCNT_W = $clog2(PAIRS + 1);

  logic                  have_lo;  // first word of a pair is held
  quant_word_t           lo_word;
  logic [WCNT_W-1:0]     wr_cnt;   // accepted writes this run
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_adr;
  logic [UI_WIDTH-1:0]   wr_data;
  logic                  accept;

  assign pop    = !empty && !wr_en;  // stall while a pair waits
  assign accept = wr_en && wr_ready;

  //////////////////////////////////////////////////
  // pair packing and write handshake
  //////////////////////////////////////////////////
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      have_lo <= 1'b0;
      wr_en   <= 1'b0;
      wr_cnt  <= '0;
      run_end <= 1'b0;
    end else if (rst) begin
      have_lo <= 1'b0;
      wr_en   <= 1'b0;
      wr_cnt  <= '0;
      run_end <= 1'b0;
    end else begin
      run_end <= accept && (wr_cnt == WCNT_W'(PAIRS - 1));
      if (run_start) begin
        wr_cnt <= '0;
        have_lo <= 1'b0;
      end else if (accept) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      if (accept) wr_en <= 1'b0;
      else if (pop && have_lo) wr_en <= 1'b1;  // second word completes the pair
      if (pop && !run_start) have_lo <= !have_lo;
    end
  end

  always_ff @(posedge clk_40M) begin
    if (pop && !have_lo) lo_word <= pop_data;
    if (pop && have_lo) begin
      wr_data <= {pop_data, lo_word};             // first word in the low half
      wr_adr  <= DST_BASE + ADDR_WIDTH'(wr_cnt);  // one address per pair
    end
  end

  assign wr_req = '{en: wr_en, adr: wr_adr, data: wr_data};

  // a stalled write holds address and data until taken
  a_wr_stable: assert property (
    @(posedge clk_40M) disable iff (!clk_40MHz_locked || rst)
    (wr_req.en && !wr_ready) |=> $stable(wr_req)
  );

endmodule

`default_nettype wire

//--- logic/quant_fifo.sv
`default_nettype none

module quant_fifo
  import conv_pkg::*;
#(
  parameter int  FIFO_DEPTH = 8,
  localparam int LVL_W      = $clog2(FIFO_DEPTH + 1)
) (
  input  wire              clk_40M,
  input  wire              clk_40MHz_locked,
  input  wire              rst,
  input  wire              push,
  input  quant_word_t      push_data,
  input  wire              pop,
  output quant_word_t      pop_data,
  output logic             empty,
  output logic [LVL_W-1:0] level
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  quant_word_t      mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;  // wraps, depth is a power of two
  logic [PTR_W-1:0] rd_ptr;

  //////////////////////////////////////////////////
  // pointers and fill level
  //////////////////////////////////////////////////
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) level <= level + 1'b1;
      else if (pop && !push) level <= level - 1'b1;
    end
  end

  always_ff @(posedge clk_40M) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  assign pop_data = mem[rd_ptr];  // head word, shows one cycle after push
  assign empty    = (level == '0);

  a_no_overflow: assert property (
    @(posedge clk_40M) disable iff (!clk_40MHz_locked) push |-> level != LVL_W'(FIFO_DEPTH)
  );

  a_no_underflow: assert property (
    @(posedge clk_40M) disable iff (!clk_40MHz_locked) pop |-> !empty
  );

endmodule

`default_nettype wire

//--- logic/quan_reader.sv
`default_nettype none

module quan_reader
  import ddr_pkg::*;
  import conv_pkg::*;
#(
  parameter int                    TEST_SIZE   = 16,
  parameter int                    QUANT_SHIFT = 4,
  parameter int                    FIFO_DEPTH  = 8,
  parameter logic [ADDR_WIDTH-1:0] SRC_BASE    = '0,
  localparam int                   LVL_W       = $clog2(FIFO_DEPTH + 1)
) (
  input  wire               clk_40M,
  input  wire               clk_40MHz_locked,
  input  wire               rst,
  input  wire               run_start,
  input  ddr_rd_rsp_t       rd_rsp,
  input  wire [LVL_W-1:0]   level,       // fifo fill
  output ddr_rd_req_t       rd_req,
  output logic              push,
  output quant_word_t       push_data
);

  localparam int ISS_W = $clog2(TEST_SIZE + 1);
  localparam logic signed [LANE_IN_W:0] HALF = (LANE_IN_W + 1)'(1) << (QUANT_SHIFT - 1);

  logic [ISS_W-1:0]      issued;       // TEST_SIZE means idle
  logic [LVL_W-1:0]      outstanding;  // issued, not yet in the fifo
  logic [LVL_W:0]        in_use;
  logic                  issue;
  logic                  rd_en;
  logic [ADDR_WIDTH-1:0] rd_adr;
  src_word_t             src;

  // round half up, arithmetic shift, clamp to a signed byte
  function automatic logic [LANE_OUT_W-1:0] quant_lane(input logic [LANE_IN_W-1:0] x);
    logic signed [LANE_IN_W:0] rnd;
    logic signed [LANE_IN_W:0] shf;
    rnd = $signed({x[LANE_IN_W-1], x}) + HALF;  // one guard bit, no overflow
    shf = rnd >>> QUANT_SHIFT;
    if (shf > Q_MAX) return LANE_OUT_W'(Q_MAX);
    if (shf < Q_MIN) return LANE_OUT_W'(Q_MIN);
    return shf[LANE_OUT_W-1:0];
  endfunction

  //////////////////////////////////////////////////
  // read issue with credits
  //////////////////////////////////////////////////
  assign in_use = {1'b0, outstanding} + {1'b0, level};
  assign issue  = (issued != ISS_W'(TEST_SIZE)) && (in_use < (LVL_W + 1)'(FIFO_DEPTH));

  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      issued      <= ISS_W'(TEST_SIZE);
      outstanding <= '0;
      rd_en       <= 1'b0;
    end else if (rst) begin
      issued      <= ISS_W'(TEST_SIZE);
      outstanding <= '0;
      rd_en       <= 1'b0;
    end else begin
      rd_en <= issue;
      if (run_start) issued <= '0;
      else if (issue) issued <= issued + 1'b1;
      // credit returns when the word lands in the fifo
      case ({issue, push})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  always_ff @(posedge clk_40M) begin
    if (issue) rd_adr <= SRC_BASE + ADDR_WIDTH'(issued);  // sequential source
  end

  assign rd_req = '{en: rd_en, adr: rd_adr};

  //////////////////////////////////////////////////
  // quantize stage
  //////////////////////////////////////////////////
  assign src = src_word_t'(rd_rsp.data);

  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) push <= 1'b0;
    else push <= rd_rsp.valid && !rst;
  end

  always_ff @(posedge clk_40M) begin
    if (rd_rsp.valid) begin
      for (int i = 0; i < LANES; i++) push_data.lane[i] <= quant_lane(src.lane[i]);
    end
  end

  // credits plus fifo fill stay within the buffer
  a_credit: assert property (
    @(posedge clk_40M) disable iff (!clk_40MHz_locked) in_use <= (LVL_W + 1)'(FIFO_DEPTH)
  );

endmodule

`default_nettype wire

//--- logic/conv_ctrl.sv
`default_nettype none

module conv_ctrl #(
  parameter int RST_CNT = 2000
) (
  input  wire  clk_40M,
  input  wire  clk_40MHz_locked,
  input  wire  test_start,  // one-cycle pulse
  input  wire  run_end,     // pulse from the writer
  output logic rst,         // internal sync reset
  output logic run_start,   // pulse to reader and writer
  output logic test_ready,
  output logic test_done
);

  localparam int CNT_W = $clog2(RST_CNT + 1);

  typedef enum logic [1:0] {
    ST_INIT,
    ST_READY,
    ST_RUN,
    ST_DONE
  } state_t;

  logic [CNT_W-1:0] rst_cnt;
  state_t           state;

  //////////////////////////////////////////////////
  // reset sequencer
  //////////////////////////////////////////////////
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      rst_cnt <= '0;
    end else if (rst_cnt != CNT_W'(RST_CNT)) begin
      rst_cnt <= rst_cnt + 1'b1;  // saturates at RST_CNT
    end
  end

  assign rst = (rst_cnt != CNT_W'(RST_CNT));

  //////////////////////////////////////////////////
  // run state machine
  //////////////////////////////////////////////////
  always_ff @(posedge clk_40M or negedge clk_40MHz_locked) begin
    if (!clk_40MHz_locked) begin
      state     <= ST_INIT;
      run_start <= 1'b0;
    end else begin
      run_start <= 1'b0;  // pulse by default
      case (state)
        ST_INIT: begin
          // leave init on the same edge that rst drops
          if (rst_cnt == CNT_W'(RST_CNT - 1)) state <= ST_READY;
        end
        ST_READY, ST_DONE: begin
          // done also takes a new start for a repeat run
          if (test_start) begin
            state     <= ST_RUN;
            run_start <= 1'b1;
          end
        end
        ST_RUN: begin
          if (run_end) state <= ST_DONE;  // starts here are dropped
        end
        default: state <= ST_INIT;
      endcase
    end
  end

  assign test_ready = (state == ST_READY) || (state == ST_DONE);
  assign test_done  = (state == ST_DONE);

  // a run never starts while the datapath is held
  a_no_start_in_rst: assert property (
    @(posedge clk_40M) disable iff (!clk_40MHz_locked) rst |-> !run_start
  );

endmodule

`default_nettype wire

//--- logic/conv_pkg.sv
`default_nettype none

// data geometry of the quantizer
package conv_pkg;

  import ddr_pkg::*;

  //////////////////////////////////////////////////
  // lane geometry
  //////////////////////////////////////////////////
  localparam int LANE_IN_W  = 16;                  // signed source lane
  localparam int LANE_OUT_W = 8;                   // signed quantized lane
  localparam int SRC_W      = DDR_WIDTH * 8;       // one source word per beat
  localparam int LANES      = SRC_W / LANE_IN_W;   // 4 lanes

  // source word as read from memory, lane 0 in the low bits
  typedef struct packed {
    logic [LANES-1:0][LANE_IN_W-1:0] lane;
  } src_word_t;

  // quantized word, 32 bit, lane 0 in the low byte
  typedef struct packed {
    logic [LANES-1:0][LANE_OUT_W-1:0] lane;
  } quant_word_t;

  // saturation limits of a quantized lane
  localparam int Q_MAX = 2 ** (LANE_OUT_W - 1) - 1;  // 127
  localparam int Q_MIN = -(2 ** (LANE_OUT_W - 1));   // -128

endpackage

`default_nettype wire

//--- logic/ddr_pkg.sv
`default_nettype none

// memory side of the engine, read and write ports
package ddr_pkg;

  //////////////////////////////////////////////////
  // port geometry
  //////////////////////////////////////////////////
  localparam int DDR_WIDTH  = 8;              // bytes per memory beat
  localparam int UI_WIDTH   = DDR_WIDTH * 8;  // 64 bit user word
  localparam int ADDR_WIDTH = 29;             // word address

  // read request, en is a one-cycle strobe
  typedef struct packed {
    logic                  en;
    logic [ADDR_WIDTH-1:0] adr;
  } ddr_rd_req_t;

  // read response, in request order
  typedef struct packed {
    logic                valid;  // one-cycle strobe
    logic [UI_WIDTH-1:0] data;
  } ddr_rd_rsp_t;

  // write request, en is a level held until wr_ready
  typedef struct packed {
    logic                  en;
    logic [ADDR_WIDTH-1:0] adr;
    logic [UI_WIDTH-1:0]   data;
  } ddr_wr_req_t;

endpackage

`default_nettype wire
